/* design/port_traffic_config.svh */
// Port counts and counter sizing for the traffic monitor
// Included by the packages and the testbench before anything sized by port count

`ifndef PORT_TRAFFIC_CONFIG_SVH
`define PORT_TRAFFIC_CONFIG_SVH

`define NUM_8B_PORTS  2
`define NUM_32B_PORTS 2
`define NUM_PORTS     (`NUM_8B_PORTS + `NUM_32B_PORTS)
`define COUNT_WIDTH   32
`define MTU_BYTES     1500

`endif

/* design/port_map_pkg.sv */
// Flat port layout and the per-port statistics record
// Shared by the statistics banks, the balance block and the top level

`include "port_traffic_config.svh"

package port_map_pkg;

    //////////////////////////////////////////////////
    // Counter types

    // Every counter in the design has this width
    typedef logic [`COUNT_WIDTH-1:0] count_t;

    typedef struct packed {
        count_t frames;
        count_t bytes;
    } port_stats_t;

    //////////////////////////////////////////////////
    // Flat port index layout

    // One bit per flat port, used for enables and clears
    typedef logic [`NUM_PORTS-1:0] port_mask_t;

    // 8-bit ports sit at the bottom of the flat index space,
    // the 32-bit ports follow directly after them
    localparam int PORT_8B_BASE  = 0;
    localparam int PORT_32B_BASE = PORT_8B_BASE + `NUM_8B_PORTS;

endpackage

/* design/axis_beat_pkg.sv */
// Packed beat records for the 8-bit and 32-bit stream ports
// The monitor looks only at valid, ready, last and keep

`include "port_traffic_config.svh"

package axis_beat_pkg;

    //////////////////////////////////////////////////
    // Beat records

    // Field names match across widths so one counter serves both
    typedef struct packed {
        logic       valid;
        logic       ready;
        logic       last;
        logic [0:0] keep;
        logic [7:0] data;
    } beat_8b_t;

    typedef struct packed {
        logic        valid;
        logic        ready;
        logic        last;
        logic [3:0]  keep;
        logic [31:0] data;
    } beat_32b_t;

endpackage

/* design/port_stats_counter.sv */
// Frame and byte counters for a single stream port
// beat_t selects the beat record; keep width follows from it

`timescale 1ns/1ps

module port_stats_counter #(
    parameter type beat_t = axis_beat_pkg::beat_8b_t
) (
    input  logic                      phys_port_clk_ifc,
    input  logic                      reset,
    input  beat_t                     beat,
    input  logic                      count_en,
    input  logic                      clear,
    output port_map_pkg::port_stats_t stats
);
    import port_map_pkg::*;

    localparam int KEEP_WIDTH = $bits(beat.keep);

    logic   xfer;
    count_t keep_bytes;

    //////////////////////////////////////////////////
    // Beat decode

    // Accepted beat on this port
    assign xfer = beat.valid & beat.ready & count_en;

    // Number of valid bytes in the beat
    always_comb begin
        keep_bytes = '0;
        for (int i = 0; i < KEEP_WIDTH; i++) begin
            keep_bytes = keep_bytes + count_t'(beat.keep[i]);
        end
    end

    //////////////////////////////////////////////////
    // Counters

    always_ff @(posedge phys_port_clk_ifc) begin
        if (reset) begin
            stats <= '0;
        end else if (clear) begin
            // Clear wins over a beat in the same cycle
            stats <= '0;
        end else if (xfer) begin
            stats.bytes <= stats.bytes + keep_bytes;
            if (beat.last) begin
                stats.frames <= stats.frames + count_t'(1);
            end
        end
    end

endmodule

/* design/ingress_stats_bank.sv */
// Statistics for every ingress port, gated by the per-port enable mask
// Results come out in flat port order, 8-bit ports first

`timescale 1ns/1ps

`include "port_traffic_config.svh"

module ingress_stats_bank (
    input  logic                      phys_port_clk_ifc,
    input  logic                      reset,
    input  axis_beat_pkg::beat_8b_t   beats_8b  [`NUM_8B_PORTS-1:0],
    input  axis_beat_pkg::beat_32b_t  beats_32b [`NUM_32B_PORTS-1:0],
    input  port_map_pkg::port_mask_t  enable,
    input  port_map_pkg::port_mask_t  clear,
    output port_map_pkg::port_stats_t stats     [`NUM_PORTS-1:0]
);
    import port_map_pkg::*;
    import axis_beat_pkg::*;

    //////////////////////////////////////////////////
    // 8-bit ingress ports

    for (genvar i = 0; i < `NUM_8B_PORTS; i++) begin : g_port_8b
        port_stats_counter #(
            .beat_t ( beat_8b_t )
        ) port_stats_counter_inst (
            .phys_port_clk_ifc ( phys_port_clk_ifc         ),
            .reset             ( reset                     ),
            .beat              ( beats_8b[i]               ),
            .count_en          ( enable[PORT_8B_BASE + i]  ),
            .clear             ( clear[PORT_8B_BASE + i]   ),
            .stats             ( stats[PORT_8B_BASE + i]   )
        );
    end

    //////////////////////////////////////////////////
    // 32-bit ingress ports

    // A disabled port still sees traffic but counts nothing
    for (genvar i = 0; i < `NUM_32B_PORTS; i++) begin : g_port_32b
        port_stats_counter #(
            .beat_t ( beat_32b_t )
        ) port_stats_counter_inst (
            .phys_port_clk_ifc ( phys_port_clk_ifc         ),
            .reset             ( reset                     ),
            .beat              ( beats_32b[i]              ),
            .count_en          ( enable[PORT_32B_BASE + i] ),
            .clear             ( clear[PORT_32B_BASE + i]  ),
            .stats             ( stats[PORT_32B_BASE + i]  )
        );
    end

endmodule

/* design/egress_stats_bank.sv */
// Statistics for every egress port, always counting
// Results come out in flat port order, 8-bit ports first

`timescale 1ns/1ps

`include "port_traffic_config.svh"

module egress_stats_bank (
    input  logic                      phys_port_clk_ifc,
    input  logic                      reset,
    input  axis_beat_pkg::beat_8b_t   beats_8b  [`NUM_8B_PORTS-1:0],
    input  axis_beat_pkg::beat_32b_t  beats_32b [`NUM_32B_PORTS-1:0],
    input  port_map_pkg::port_mask_t  clear,
    output port_map_pkg::port_stats_t stats     [`NUM_PORTS-1:0]
);
    import port_map_pkg::*;
    import axis_beat_pkg::*;

    //////////////////////////////////////////////////
    // 8-bit egress ports

    // No enable on this side
    for (genvar i = 0; i < `NUM_8B_PORTS; i++) begin : g_port_8b
        port_stats_counter #(
            .beat_t ( beat_8b_t )
        ) port_stats_counter_inst (
            .phys_port_clk_ifc ( phys_port_clk_ifc        ),
            .reset             ( reset                    ),
            .beat              ( beats_8b[i]              ),
            .count_en          ( 1'b1                     ),
            .clear             ( clear[PORT_8B_BASE + i]  ),
            .stats             ( stats[PORT_8B_BASE + i]  )
        );
    end

    //////////////////////////////////////////////////
    // 32-bit egress ports

    for (genvar i = 0; i < `NUM_32B_PORTS; i++) begin : g_port_32b
        port_stats_counter #(
            .beat_t ( beat_32b_t )
        ) port_stats_counter_inst (
            .phys_port_clk_ifc ( phys_port_clk_ifc        ),
            .reset             ( reset                    ),
            .beat              ( beats_32b[i]             ),
            .count_en          ( 1'b1                     ),
            .clear             ( clear[PORT_32B_BASE + i] ),
            .stats             ( stats[PORT_32B_BASE + i] )
        );
    end

endmodule

/* design/traffic_balance.sv */
// Compares total ingress traffic against total egress traffic
// Outputs lag the port statistics by one register stage

`timescale 1ns/1ps

`include "port_traffic_config.svh"

module traffic_balance (
    input  logic                      phys_port_clk_ifc,
    input  logic                      reset,
    input  port_map_pkg::port_stats_t ing_stats [`NUM_PORTS-1:0],
    input  port_map_pkg::port_stats_t egr_stats [`NUM_PORTS-1:0],
    output port_map_pkg::count_t      frames_in_flight,
    output port_map_pkg::count_t      bytes_in_flight,
    output logic                      balanced
);
    import port_map_pkg::*;

    count_t ing_frames_sum;
    count_t ing_bytes_sum;
    count_t egr_frames_sum;
    count_t egr_bytes_sum;
    count_t frames_diff;
    count_t bytes_diff;

    //////////////////////////////////////////////////
    // Sums over all ports

    // Wraps modulo 2^COUNT_WIDTH, same as the port counters
    always_comb begin
        ing_frames_sum = '0;
        ing_bytes_sum  = '0;
        egr_frames_sum = '0;
        egr_bytes_sum  = '0;
        for (int p = 0; p < `NUM_PORTS; p++) begin
            ing_frames_sum = ing_frames_sum + ing_stats[p].frames;
            ing_bytes_sum  = ing_bytes_sum + ing_stats[p].bytes;
            egr_frames_sum = egr_frames_sum + egr_stats[p].frames;
            egr_bytes_sum  = egr_bytes_sum + egr_stats[p].bytes;
        end
    end

    assign frames_diff = ing_frames_sum - egr_frames_sum;
    assign bytes_diff  = ing_bytes_sum - egr_bytes_sum;

    //////////////////////////////////////////////////
    // Registered in-flight totals

    always_ff @(posedge phys_port_clk_ifc) begin
        if (reset) begin
            frames_in_flight <= '0;
            bytes_in_flight  <= '0;
            balanced         <= 1'b1;
        end else begin
            frames_in_flight <= frames_diff;
            bytes_in_flight  <= bytes_diff;
            // Both frame and byte totals must agree
            balanced         <= (frames_diff == '0) && (bytes_diff == '0);
        end
    end

endmodule

/* design/port_traffic_monitor.sv */
// Passive traffic monitor across the 8-bit and 32-bit stream ports
// Observes handshakes only and never drives ready

`timescale 1ns/1ps

`include "port_traffic_config.svh"

module port_traffic_monitor (
    input  logic                      phys_port_clk_ifc,
    input  logic                      reset,
    // Ingress side
    input  axis_beat_pkg::beat_8b_t   ing_beats_8b  [`NUM_8B_PORTS-1:0],
    input  axis_beat_pkg::beat_32b_t  ing_beats_32b [`NUM_32B_PORTS-1:0],
    input  port_map_pkg::port_mask_t  ing_enable,
    input  port_map_pkg::port_mask_t  ing_clear,
    // Egress side
    input  axis_beat_pkg::beat_8b_t   egr_beats_8b  [`NUM_8B_PORTS-1:0],
    input  axis_beat_pkg::beat_32b_t  egr_beats_32b [`NUM_32B_PORTS-1:0],
    input  port_map_pkg::port_mask_t  egr_clear,
    // Statistics, flat port order
    output port_map_pkg::port_stats_t ing_stats     [`NUM_PORTS-1:0],
    output port_map_pkg::port_stats_t egr_stats     [`NUM_PORTS-1:0],
    output port_map_pkg::count_t      frames_in_flight,
    output port_map_pkg::count_t      bytes_in_flight,
    output logic                      balanced
);

    //////////////////////////////////////////////////
    // Per-port statistics

    ingress_stats_bank ingress_stats_bank_inst (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .reset             ( reset             ),
        .beats_8b          ( ing_beats_8b      ),
        .beats_32b         ( ing_beats_32b     ),
        .enable            ( ing_enable        ),
        .clear             ( ing_clear         ),
        .stats             ( ing_stats         )
    );

    egress_stats_bank egress_stats_bank_inst (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .reset             ( reset             ),
        .beats_8b          ( egr_beats_8b      ),
        .beats_32b         ( egr_beats_32b     ),
        .clear             ( egr_clear         ),
        .stats             ( egr_stats         )
    );

    //////////////////////////////////////////////////
    // Ingress versus egress

    traffic_balance traffic_balance_inst (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .reset             ( reset             ),
        .ing_stats         ( ing_stats         ),
        .egr_stats         ( egr_stats         ),
        .frames_in_flight  ( frames_in_flight  ),
        .bytes_in_flight   ( bytes_in_flight   ),
        .balanced          ( balanced          )
    );

endmodule

/* bench/port_traffic_checker.sv */
// Reference model of the port traffic monitor, fed from the same inputs as the DUT
// Compares stats and balance outputs with the model on every falling clock edge

`timescale 1ns/1ps

`include "port_traffic_config.svh"

module port_traffic_checker (
    input  logic                      phys_port_clk_ifc,
    input  logic                      reset,
    input  axis_beat_pkg::beat_8b_t   ing_beats_8b  [`NUM_8B_PORTS-1:0],
    input  axis_beat_pkg::beat_32b_t  ing_beats_32b [`NUM_32B_PORTS-1:0],
    input  port_map_pkg::port_mask_t  ing_enable,
    input  port_map_pkg::port_mask_t  ing_clear,
    input  axis_beat_pkg::beat_8b_t   egr_beats_8b  [`NUM_8B_PORTS-1:0],
    input  axis_beat_pkg::beat_32b_t  egr_beats_32b [`NUM_32B_PORTS-1:0],
    input  port_map_pkg::port_mask_t  egr_clear,
    input  port_map_pkg::port_stats_t ing_stats     [`NUM_PORTS-1:0],
    input  port_map_pkg::port_stats_t egr_stats     [`NUM_PORTS-1:0],
    input  port_map_pkg::count_t      frames_in_flight,
    input  port_map_pkg::count_t      bytes_in_flight,
    input  logic                      balanced,
    input  logic                      row_done,
    input  logic                      row_balanced,
    output int                        error_count,
    output int                        check_count
);
    import port_map_pkg::*;

    port_stats_t exp_ing [`NUM_PORTS];
    port_stats_t exp_egr [`NUM_PORTS];
    count_t      exp_frames_in_flight;
    count_t      exp_bytes_in_flight;
    logic        exp_balanced;
    logic        started = 1'b0;
    int          errors  = 0;
    int          checks  = 0;

    assign error_count = errors;
    assign check_count = checks;

    // One port after a clock edge: clear first, then an accepted beat
    function automatic port_stats_t advance_stats(input port_stats_t cur, input logic xfer,
                                                  input logic last, input int nbytes,
                                                  input logic clr);
        port_stats_t nxt;
        nxt = cur;
        if (clr) begin
            nxt = '0;
        end else if (xfer) begin
            nxt.bytes = cur.bytes + count_t'(nbytes);
            if (last) begin
                nxt.frames = cur.frames + count_t'(1);
            end
        end
        return nxt;
    endfunction

    task automatic check_value(input string what, input count_t got, input count_t expected);
        checks = checks + 1;
        if (got !== expected) begin
            errors = errors + 1;
            $display("** Error at time %0t: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    //////////////////////////////////////////////////
    // Reference model

    always @(posedge phys_port_clk_ifc) begin
        count_t ing_frames;
        count_t ing_bytes;
        count_t egr_frames;
        count_t egr_bytes;
        ing_frames = '0;
        ing_bytes  = '0;
        egr_frames = '0;
        egr_bytes  = '0;
        if (reset) begin
            started <= 1'b1;
            for (int p = 0; p < `NUM_PORTS; p++) begin
                exp_ing[p] <= '0;
                exp_egr[p] <= '0;
            end
            exp_frames_in_flight <= '0;
            exp_bytes_in_flight  <= '0;
            exp_balanced         <= 1'b1;
        end else begin
            // Totals use the stats as they stood before this edge
            for (int p = 0; p < `NUM_PORTS; p++) begin
                ing_frames = ing_frames + exp_ing[p].frames;
                ing_bytes  = ing_bytes + exp_ing[p].bytes;
                egr_frames = egr_frames + exp_egr[p].frames;
                egr_bytes  = egr_bytes + exp_egr[p].bytes;
            end
            exp_frames_in_flight <= ing_frames - egr_frames;
            exp_bytes_in_flight  <= ing_bytes - egr_bytes;
            exp_balanced         <= (ing_frames == egr_frames) && (ing_bytes == egr_bytes);
            for (int i = 0; i < `NUM_8B_PORTS; i++) begin
                exp_ing[PORT_8B_BASE + i] <= advance_stats(exp_ing[PORT_8B_BASE + i],
                    ing_beats_8b[i].valid && ing_beats_8b[i].ready && ing_enable[PORT_8B_BASE + i],
                    ing_beats_8b[i].last, $countones(ing_beats_8b[i].keep),
                    ing_clear[PORT_8B_BASE + i]);
                exp_egr[PORT_8B_BASE + i] <= advance_stats(exp_egr[PORT_8B_BASE + i],
                    egr_beats_8b[i].valid && egr_beats_8b[i].ready,
                    egr_beats_8b[i].last, $countones(egr_beats_8b[i].keep),
                    egr_clear[PORT_8B_BASE + i]);
            end
            for (int i = 0; i < `NUM_32B_PORTS; i++) begin
                exp_ing[PORT_32B_BASE + i] <= advance_stats(exp_ing[PORT_32B_BASE + i],
                    ing_beats_32b[i].valid && ing_beats_32b[i].ready
                        && ing_enable[PORT_32B_BASE + i],
                    ing_beats_32b[i].last, $countones(ing_beats_32b[i].keep),
                    ing_clear[PORT_32B_BASE + i]);
                exp_egr[PORT_32B_BASE + i] <= advance_stats(exp_egr[PORT_32B_BASE + i],
                    egr_beats_32b[i].valid && egr_beats_32b[i].ready,
                    egr_beats_32b[i].last, $countones(egr_beats_32b[i].keep),
                    egr_clear[PORT_32B_BASE + i]);
            end
        end
    end

    //////////////////////////////////////////////////
    // Comparison, half a cycle after each update

    always @(negedge phys_port_clk_ifc) begin
        if (started) begin
            for (int p = 0; p < `NUM_PORTS; p++) begin
                check_value($sformatf("ingress port %0d frames", p),
                            ing_stats[p].frames, exp_ing[p].frames);
                check_value($sformatf("ingress port %0d bytes", p),
                            ing_stats[p].bytes, exp_ing[p].bytes);
                check_value($sformatf("egress port %0d frames", p),
                            egr_stats[p].frames, exp_egr[p].frames);
                check_value($sformatf("egress port %0d bytes", p),
                            egr_stats[p].bytes, exp_egr[p].bytes);
            end
            check_value("frames_in_flight", frames_in_flight, exp_frames_in_flight);
            check_value("bytes_in_flight", bytes_in_flight, exp_bytes_in_flight);
            check_value("balanced", count_t'(balanced), count_t'(exp_balanced));
            // Table value for the row that just settled
            if (row_done) begin
                check_value("balanced at end of row", count_t'(balanced),
                            count_t'(row_balanced));
            end
        end
    end

endmodule

/* bench/tb_port_traffic_monitor.sv */
// Testbench for the port traffic monitor: clock, reset and a table of stimulus rows
// Each row is driven for its repeat count, then the bus idles while balanced settles

`timescale 1ns/1ps

`include "port_traffic_config.svh"

module tb_port_traffic_monitor;
    import port_map_pkg::*;
    import axis_beat_pkg::*;

    localparam int NUM_ROWS      = 14;
    localparam int SETTLE_CYCLES = 2;
    localparam int RESET_CYCLES  = 2;

    typedef struct packed {
        port_mask_t ing_valid;
        port_mask_t ing_ready;
        port_mask_t ing_last;
        port_mask_t egr_valid;
        port_mask_t egr_ready;
        port_mask_t egr_last;
        logic [0:0] keep8;
        logic [3:0] keep32;
        logic       rand_keep;
        port_mask_t ing_enable;
        port_mask_t ing_clear;
        port_mask_t egr_clear;
        int         reps;
        logic       exp_balanced;
    } row_t;

    localparam row_t IDLE_ROW = '0;

    // iv, ir, il, ev, er, el, keep8, keep32, rand, enable, ing clr, egr clr, reps, balanced
    // Flat ports 0 and 1 are 8-bit, 2 and 3 are 32-bit
    localparam row_t ROWS [NUM_ROWS] = '{
        '{4'h5, 4'hF, 4'h0, 4'h0, 4'hF, 4'h0, 1'b1, 4'hF, 1'b0, 4'hF, 4'h0, 4'h0, 3, 1'b0},
        '{4'h5, 4'hF, 4'h5, 4'h0, 4'hF, 4'h0, 1'b1, 4'h7, 1'b0, 4'hF, 4'h0, 4'h0, 1, 1'b0},
        '{4'h0, 4'hF, 4'h0, 4'h5, 4'hF, 4'h0, 1'b1, 4'hF, 1'b0, 4'hF, 4'h0, 4'h0, 3, 1'b0},
        '{4'h0, 4'hF, 4'h0, 4'h5, 4'hF, 4'h5, 1'b1, 4'h7, 1'b0, 4'hF, 4'h0, 4'h0, 1, 1'b1},
        '{4'h2, 4'hF, 4'h2, 4'h0, 4'hF, 4'h0, 1'b1, 4'hF, 1'b0, 4'hD, 4'h0, 4'h0, 2, 1'b1},
        '{4'hF, 4'h0, 4'hF, 4'hF, 4'h0, 4'hF, 1'b1, 4'hF, 1'b0, 4'hF, 4'h0, 4'h0, 2, 1'b1},
        '{4'h8, 4'hF, 4'h8, 4'h8, 4'hF, 4'h8, 1'b1, 4'hF, 1'b1, 4'hF, 4'h0, 4'h0, 4, 1'b1},
        '{4'hA, 4'hF, 4'hA, 4'h0, 4'hF, 4'h0, 1'b1, 4'hF, 1'b1, 4'hF, 4'h0, 4'h0, 3, 1'b0},
        '{4'h2, 4'hF, 4'h2, 4'h0, 4'hF, 4'h0, 1'b1, 4'hF, 1'b0, 4'hF, 4'h2, 4'h0, 1, 1'b0},
        '{4'h8, 4'hF, 4'h8, 4'h0, 4'hF, 4'h0, 1'b1, 4'hF, 1'b0, 4'hF, 4'h8, 4'h0, 1, 1'b0},
        '{4'h0, 4'hF, 4'h0, 4'h0, 4'hF, 4'h0, 1'b1, 4'hF, 1'b0, 4'hF, 4'h0, 4'h8, 1, 1'b1},
        '{4'h0, 4'hF, 4'h0, 4'h0, 4'hF, 4'h0, 1'b1, 4'hF, 1'b0, 4'hF, 4'hF, 4'hF, 1, 1'b1},
        '{4'h0, 4'hF, 4'h0, 4'h1, 4'hF, 4'h1, 1'b1, 4'hF, 1'b0, 4'hF, 4'h0, 4'h0, 2, 1'b0},
        '{4'h1, 4'hF, 4'h1, 4'h0, 4'hF, 4'h0, 1'b1, 4'hF, 1'b0, 4'hF, 4'h0, 4'h0, 2, 1'b1}
    };

    logic        phys_port_clk_ifc;
    logic        reset;
    beat_8b_t    ing_beats_8b  [`NUM_8B_PORTS-1:0];
    beat_32b_t   ing_beats_32b [`NUM_32B_PORTS-1:0];
    port_mask_t  ing_enable;
    port_mask_t  ing_clear;
    beat_8b_t    egr_beats_8b  [`NUM_8B_PORTS-1:0];
    beat_32b_t   egr_beats_32b [`NUM_32B_PORTS-1:0];
    port_mask_t  egr_clear;
    port_stats_t ing_stats     [`NUM_PORTS-1:0];
    port_stats_t egr_stats     [`NUM_PORTS-1:0];
    count_t      frames_in_flight;
    count_t      bytes_in_flight;
    logic        balanced;
    logic        row_done;
    logic        row_balanced;
    int          error_count;
    int          check_count;
    int unsigned lcg_state   = 23;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          total_reps  = 0;

    port_traffic_monitor port_traffic_monitor_inst (.*);

    port_traffic_checker port_traffic_checker_inst (.*);

    //////////////////////////////////////////////////
    // Clock and timeout

    initial begin
        phys_port_clk_ifc = 1'b0;
        forever #20 phys_port_clk_ifc = ~phys_port_clk_ifc;
    end

    always @(posedge phys_port_clk_ifc) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, the stimulus table never finished", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Stimulus helpers

    function automatic logic [3:0] next_random_keep();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[19:16];
    endfunction

    function automatic beat_8b_t beat_8b_from_masks(input port_mask_t v, input port_mask_t r,
                                                    input port_mask_t l, input int p,
                                                    input logic [0:0] k);
        return '{v[p], r[p], l[p], k, 8'(p)};
    endfunction

    function automatic beat_32b_t beat_32b_from_masks(input port_mask_t v, input port_mask_t r,
                                                      input port_mask_t l, input int p,
                                                      input logic [3:0] k);
        return '{v[p], r[p], l[p], k, 32'hC0DE_0000 + 32'(p)};
    endfunction

    // Both sides share the keep of a cycle, random keeps stay matched
    task automatic apply_row(input row_t row);
        logic [3:0] keep_now;
        keep_now = row.rand_keep ? next_random_keep() : row.keep32;
        for (int i = 0; i < `NUM_8B_PORTS; i++) begin
            ing_beats_8b[i] = beat_8b_from_masks(row.ing_valid, row.ing_ready, row.ing_last,
                                                 PORT_8B_BASE + i, row.keep8);
            egr_beats_8b[i] = beat_8b_from_masks(row.egr_valid, row.egr_ready, row.egr_last,
                                                 PORT_8B_BASE + i, row.keep8);
        end
        for (int i = 0; i < `NUM_32B_PORTS; i++) begin
            ing_beats_32b[i] = beat_32b_from_masks(row.ing_valid, row.ing_ready, row.ing_last,
                                                   PORT_32B_BASE + i, keep_now);
            egr_beats_32b[i] = beat_32b_from_masks(row.egr_valid, row.egr_ready, row.egr_last,
                                                   PORT_32B_BASE + i, keep_now);
        end
        ing_enable = row.ing_enable;
        ing_clear  = row.ing_clear;
        egr_clear  = row.egr_clear;
    endtask

    //////////////////////////////////////////////////
    // Main sequence

    initial begin
        reset        = 1'b1;
        row_done     = 1'b0;
        row_balanced = 1'b1;
        apply_row(IDLE_ROW);
        for (int r = 0; r < NUM_ROWS; r++) begin
            total_reps = total_reps + ROWS[r].reps;
        end
        cycle_limit = total_reps + SETTLE_CYCLES * NUM_ROWS + RESET_CYCLES + 20;

        repeat (RESET_CYCLES) @(posedge phys_port_clk_ifc);
        #2;
        reset = 1'b0;

        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int c = 0; c < ROWS[r].reps; c++) begin
                @(posedge phys_port_clk_ifc);
                #2;
                row_done = 1'b0;
                apply_row(ROWS[r]);
            end
            // Idle until the balance outputs have caught up with the row
            for (int s = 0; s < SETTLE_CYCLES; s++) begin
                @(posedge phys_port_clk_ifc);
                #2;
                apply_row(IDLE_ROW);
                row_balanced = ROWS[r].exp_balanced;
                row_done     = (s == SETTLE_CYCLES - 1);
            end
        end

        @(posedge phys_port_clk_ifc);
        #2;
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* port_traffic_monitor.f */
+incdir+design
design/port_map_pkg.sv
design/axis_beat_pkg.sv
design/port_stats_counter.sv
design/ingress_stats_bank.sv
design/egress_stats_bank.sv
design/traffic_balance.sv
design/port_traffic_monitor.sv
bench/port_traffic_checker.sv
bench/tb_port_traffic_monitor.sv

/* run_sim.sh */
#!/bin/sh
# Build the port traffic monitor testbench with Verilator and run it.
# Exit status is 0 only when the pass message appears in the simulation output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_port_traffic_monitor \
    -f port_traffic_monitor.f -o tb_port_traffic_monitor_sim \
    && ./obj_dir/tb_port_traffic_monitor_sim | tee /dev/stderr \
        | grep -x "Simulation completed successfully" > /dev/null \
    && echo "Result: PASS" \
    || { echo "Result: FAIL"; exit 1; }
